//--- rv_processor.f
+incdir+dv
common/rv_core_pkg.sv
core/rv_decoder.sv
core/rv_regfile.sv
core/rv_alu.sv
core/rv_next_pc.sv
core/rv_lsu.sv
core/rv_core.sv
source/rv_memory.sv
source/rv_processor.sv
dv/tb_rv_processor.sv

//--- Bender.yml
package:
  name: rv_processor

sources:
  - common/rv_core_pkg.sv
  - core/rv_decoder.sv
  - core/rv_regfile.sv
  - core/rv_alu.sv
  - core/rv_next_pc.sv
  - core/rv_lsu.sv
  - core/rv_core.sv
  - source/rv_memory.sv
  - source/rv_processor.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_rv_processor.sv

//--- dv/rv_ref_model.svh
////////////////////////////////////////
// Reference model and random program generator
// Included inside the processor testbench module
////////////////////////////////////////
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

word_t model_regs [32];
word_t model_mem [MEM_WORDS];
word_t model_pc;

// Byte offset in [lo, 2047] aligned to the access size
function automatic logic [11:0] aligned_offset(int unsigned lo, logic [1:0] size);
  int unsigned byte_addr;
  byte_addr = $urandom_range(lo, 2047);
  byte_addr = byte_addr & ~((32'd1 << size) - 1);
  return byte_addr[11:0];
endfunction

// One legal instruction for word idx with only forward control flow
function automatic word_t random_insn(int unsigned idx);
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  funct3_t     f3;
  logic [6:0]  f7;
  logic [11:0] imm12;
  logic [20:0] off;
  logic        coin;
  int unsigned sel;
  word_t       insn;
  rd    = reg_idx_t'($urandom_range(0, 31));
  rs1   = reg_idx_t'($urandom_range(0, 31));
  rs2   = reg_idx_t'($urandom_range(0, 31));
  f3    = funct3_t'($urandom_range(0, 7));
  coin  = 1'($urandom_range(0, 1));
  off   = 21'(4 * $urandom_range(1, 16));
  imm12 = 12'($urandom());
  case ($urandom_range(0, 9))
    0, 1: begin
      f7   = (coin && (f3 == 3'b000 || f3 == 3'b101)) ? FUNCT7_ALT : 7'b0;
      insn = {f7, rs2, rs1, f3, rd, OP_REG_REG};
    end
    2, 3: begin
      // Shift immediates carry funct7 in the upper bits
      if (f3 == 3'b001) begin
        imm12[11:5] = 7'b0;
      end else if (f3 == 3'b101) begin
        imm12[11:5] = coin ? FUNCT7_ALT : 7'b0;
      end
      insn = {imm12, rs1, f3, rd, OP_REG_IMM};
    end
    4: insn = {20'($urandom()), rd, coin ? OP_LUI : OP_AUIPC};
    5: begin
      sel  = $urandom_range(0, 5);
      f3   = funct3_t'((sel < 2) ? sel : sel + 2);
      insn = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    end
    6: begin
      if (coin) begin
        insn = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
      end else begin
        imm12 = 12'(4 * $urandom_range(idx + 1, 255));
        insn  = {imm12, 5'd0, 3'b000, rd, OP_JALR};
      end
    end
    7: begin
      sel   = $urandom_range(0, 4);
      f3    = funct3_t'((sel < 3) ? sel : sel + 1);
      imm12 = aligned_offset(1024, f3[1:0]);
      insn  = {imm12, 5'd0, f3, rd, OP_LOAD};
    end
    8: begin
      // Stores stay above any word a forward jump can reach
      f3    = funct3_t'($urandom_range(0, 2));
      imm12 = aligned_offset(1536, f3[1:0]);
      insn  = {imm12[11:5], rs2, 5'd0, f3, imm12[4:0], OP_STORE};
    end
    default: insn = {4'b0, 8'hff, 5'd0, 3'b000, 5'd0, OP_MISC_MEM};
  endcase
  return insn;
endfunction

function automatic void build_program();
  for (int i = 0; i < MEM_WORDS; i++) begin
    if (i < 255) begin
      model_mem[i] = random_insn(i);
    end else if (i < 512) begin
      model_mem[i] = {25'b0, OP_ENVIRON};
    end else begin
      model_mem[i] = $urandom();
    end
  end
endfunction

function automatic void reset_model();
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  model_pc = RESET_PC;
endfunction

function automatic word_t exec_alu(funct3_t f3, logic alt, word_t a, word_t b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return word_t'($signed(a) < $signed(b));
    3'b011:  return word_t'(a < b);
    3'b100:  return a ^ b;
    3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// Executes the instruction at model_pc and reports what it commits
function automatic void step_model(output logic rd_we, output reg_idx_t rd,
                                   output word_t rd_data, output byte_en_t st_en,
                                   output word_t st_addr, output word_t st_data,
                                   output logic ecall);
  word_t     insn;
  word_t     a;
  word_t     b;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_j;
  word_t     ea;
  word_t     w;
  word_t     next_pc;
  funct3_t   f3;
  logic      taken;
  mem_addr_t idx;
  insn    = model_mem[model_pc[MEM_ADDR_W+1:2]];
  f3      = insn[14:12];
  rd      = insn[11:7];
  a       = model_regs[insn[19:15]];
  b       = model_regs[insn[24:20]];
  imm_i   = {{20{insn[31]}}, insn[31:20]};
  imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  imm_b   = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  imm_j   = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  rd_we   = 1'b0;
  rd_data = '0;
  st_en   = '0;
  st_addr = '0;
  st_data = '0;
  ecall   = 1'b0;
  next_pc = model_pc + 32'd4;
  case (insn[6:0])
    OP_REG_REG: begin
      rd_we   = 1'b1;
      rd_data = exec_alu(f3, insn[30], a, b);
    end
    OP_REG_IMM: begin
      rd_we   = 1'b1;
      rd_data = exec_alu(f3, insn[30] && f3 == 3'b101, a, imm_i);
    end
    OP_LUI: begin
      rd_we   = 1'b1;
      rd_data = {insn[31:12], 12'b0};
    end
    OP_AUIPC: begin
      rd_we   = 1'b1;
      rd_data = model_pc + {insn[31:12], 12'b0};
    end
    OP_JAL: begin
      rd_we   = 1'b1;
      rd_data = model_pc + 32'd4;
      next_pc = model_pc + imm_j;
    end
    OP_JALR: begin
      rd_we   = 1'b1;
      rd_data = model_pc + 32'd4;
      next_pc = (a + imm_i) & ~32'd1;
    end
    OP_BRANCH: begin
      case (f3)
        3'b000:  taken = (a == b);
        3'b001:  taken = (a != b);
        3'b100:  taken = $signed(a) < $signed(b);
        3'b101:  taken = $signed(a) >= $signed(b);
        3'b110:  taken = a < b;
        default: taken = a >= b;
      endcase
      if (taken) begin
        next_pc = model_pc + imm_b;
      end
    end
    OP_LOAD: begin
      ea    = a + imm_i;
      idx   = ea[MEM_ADDR_W+1:2];
      w     = model_mem[idx] >> (8 * ea[1:0]);
      rd_we = 1'b1;
      case (f3)
        3'b000:  rd_data = {{24{w[7]}}, w[7:0]};
        3'b001:  rd_data = {{16{w[15]}}, w[15:0]};
        3'b100:  rd_data = {24'b0, w[7:0]};
        3'b101:  rd_data = {16'b0, w[15:0]};
        default: rd_data = model_mem[idx];
      endcase
    end
    OP_STORE: begin
      ea      = a + imm_s;
      idx     = ea[MEM_ADDR_W+1:2];
      st_addr = {ea[31:2], 2'b00};
      case (f3)
        3'b000: begin
          st_en   = byte_en_t'(4'b0001 << ea[1:0]);
          st_data = {4{b[7:0]}};
        end
        3'b001: begin
          st_en   = byte_en_t'(4'b0011 << ea[1:0]);
          st_data = {2{b[15:0]}};
        end
        default: begin
          st_en   = 4'b1111;
          st_data = b;
        end
      endcase
      for (int i = 0; i < 4; i++) begin
        if (st_en[i]) begin
          model_mem[idx][8*i +: 8] = st_data[8*i +: 8];
        end
      end
    end
    OP_ENVIRON: begin
      ecall   = 1'b1;
      next_pc = model_pc;
    end
    // fence
    default: ;
  endcase
  if (rd_we && rd != '0) begin
    model_regs[rd] = rd_data;
  end
  model_pc = next_pc;
endfunction

`endif

//--- dv/tb_rv_processor.sv
////////////////////////////////////////
// Testbench for the RV32I processor with random
// programs checked against a reference model
////////////////////////////////////////
module tb_rv_processor;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_core_pkg::*;

  localparam int NUM_PROGRAMS  = 8;
  localparam int RESET_CYCLES  = 5;
  localparam int MAX_RETIRE    = 256;
  localparam int HALT_CYCLES   = 8;
  localparam int CLK_PERIOD_NS = 8;
  localparam int WATCHDOG_NS   =
    NUM_PROGRAMS * (MEM_WORDS + RESET_CYCLES + MAX_RETIRE + 16) * CLK_PERIOD_NS;

  logic      clk;
  logic      rst;
  logic      load_we;
  mem_addr_t load_addr;
  word_t     load_data;
  logic      halt;
  logic      retire_valid;
  word_t     retire_pc;
  logic      retire_rd_we;
  reg_idx_t  retire_rd;
  word_t     retire_rd_data;
  byte_en_t  retire_store_en;
  word_t     retire_store_addr;
  word_t     retire_store_data;

  `include "rv_ref_model.svh"

  rv_processor u_rv_processor (
    .clk               (clk),
    .rst               (rst),
    .load_we           (load_we),
    .load_addr         (load_addr),
    .load_data         (load_data),
    .halt              (halt),
    .retire_valid      (retire_valid),
    .retire_pc         (retire_pc),
    .retire_rd_we      (retire_rd_we),
    .retire_rd         (retire_rd),
    .retire_rd_data    (retire_rd_data),
    .retire_store_en   (retire_store_en),
    .retire_store_addr (retire_store_addr),
    .retire_store_data (retire_store_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_reg_idx(string name, reg_idx_t exp, reg_idx_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte_en(string name, byte_en_t exp, byte_en_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // Reset, then program load while reset stays high
  task automatic load_program();
    @(posedge clk);
    rst     <= 1'b1;
    load_we <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    check_bit("halt", 1'b0, halt);
    check_bit("retire_valid", 1'b0, retire_valid);
    check_bit("retire_rd_we", 1'b0, retire_rd_we);
    check_byte_en("retire_store_en", '0, retire_store_en);
    check_word("retire_pc", 32'h0, retire_pc);
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      load_we   <= 1'b1;
      load_addr <= mem_addr_t'(i);
      load_data <= model_mem[i];
    end
    @(posedge clk);
    load_we <= 1'b0;
    rst     <= 1'b0;
  endtask

  // Compares one retired instruction with the model
  task automatic check_retire(output logic ecall);
    logic     exp_we;
    reg_idx_t exp_rd;
    word_t    exp_rd_data;
    byte_en_t exp_st_en;
    word_t    exp_st_addr;
    word_t    exp_st_data;
    check_bit("retire_valid", 1'b1, retire_valid);
    check_bit("halt", 1'b0, halt);
    check_word("retire_pc", model_pc, retire_pc);
    step_model(exp_we, exp_rd, exp_rd_data, exp_st_en, exp_st_addr, exp_st_data, ecall);
    check_bit("retire_rd_we", exp_we, retire_rd_we);
    if (exp_we) begin
      check_reg_idx("retire_rd", exp_rd, retire_rd);
      // x0 keeps zero in the model and later reads cover it
      if (exp_rd != '0) begin
        check_word("retire_rd_data", exp_rd_data, retire_rd_data);
      end
    end
    check_byte_en("retire_store_en", exp_st_en, retire_store_en);
    if (exp_st_en != '0) begin
      check_word("retire_store_addr", exp_st_addr, retire_store_addr);
      check_word("retire_store_data", exp_st_data, retire_store_data);
    end
  endtask

  task automatic run_program(int prog);
    logic ecall;
    int   retired;
    ecall   = 1'b0;
    retired = 0;
    while (!ecall) begin
      @(negedge clk);
      if (retired == MAX_RETIRE) begin
        $display("Program %0d ran past %0d instructions without an ecall", prog, MAX_RETIRE);
        abort_run();
      end
      check_retire(ecall);
      retired++;
    end
    // Once halted the pc holds on the ecall and nothing commits
    for (int i = 0; i <= HALT_CYCLES; i++) begin
      @(negedge clk);
      check_bit("halt", 1'b1, halt);
      check_bit("retire_valid", 1'b0, retire_valid);
      check_bit("retire_rd_we", 1'b0, retire_rd_we);
      check_byte_en("retire_store_en", '0, retire_store_en);
      check_word("retire_pc", model_pc, retire_pc);
    end
    $display("Program %0d halted after %0d instructions", prog, retired);
  endtask

  initial begin
    rst       = 1'b1;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(99));
    for (int p = 0; p < NUM_PROGRAMS; p++) begin
      build_program();
      reset_model();
      load_program();
      run_program(p);
    end
    $display("** PASS **");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Processor never halted within the time allowed for %0d programs", NUM_PROGRAMS);
    abort_run();
  end

endmodule

//--- source/rv_processor.sv
////////////////////////////////////////
// Processor top: core plus unified memory
////////////////////////////////////////
module rv_processor (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load_we,
  input  rv_core_pkg::mem_addr_t load_addr,
  input  rv_core_pkg::word_t     load_data,
  output logic                   halt,
  output logic                   retire_valid,
  output rv_core_pkg::word_t     retire_pc,
  output logic                   retire_rd_we,
  output rv_core_pkg::reg_idx_t  retire_rd,
  output rv_core_pkg::word_t     retire_rd_data,
  output rv_core_pkg::byte_en_t  retire_store_en,
  output rv_core_pkg::word_t     retire_store_addr,
  output rv_core_pkg::word_t     retire_store_data
);
  import rv_core_pkg::*;

  word_t    fetch_pc;
  word_t    insn;
  word_t    data_addr;
  byte_en_t store_en;
  word_t    store_data;
  word_t    mem_rdata;

  rv_core u_core (
    .clk               (clk),
    .rst               (rst),
    .insn              (insn),
    .load_data         (mem_rdata),
    .fetch_pc          (fetch_pc),
    .data_addr         (data_addr),
    .store_en          (store_en),
    .store_data        (store_data),
    .halt              (halt),
    .retire_valid      (retire_valid),
    .retire_pc         (retire_pc),
    .retire_rd_we      (retire_rd_we),
    .retire_rd         (retire_rd),
    .retire_rd_data    (retire_rd_data),
    .retire_store_en   (retire_store_en),
    .retire_store_addr (retire_store_addr),
    .retire_store_data (retire_store_data)
  );

  rv_memory u_memory (
    .clk        (clk),
    .rst        (rst),
    .load_we    (load_we),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_pc   (fetch_pc),
    .data_addr  (data_addr),
    .store_en   (store_en),
    .store_data (store_data),
    .insn       (insn),
    .mem_rdata  (mem_rdata)
  );

endmodule

//--- source/rv_memory.sv
////////////////////////////////////////
// Unified word memory, loaded during reset,
// async reads and byte-enabled writes
////////////////////////////////////////
module rv_memory (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load_we,
  input  rv_core_pkg::mem_addr_t load_addr,
  input  rv_core_pkg::word_t     load_data,
  input  rv_core_pkg::word_t     fetch_pc,
  input  rv_core_pkg::word_t     data_addr,
  input  rv_core_pkg::byte_en_t  store_en,
  input  rv_core_pkg::word_t     store_data,
  output rv_core_pkg::word_t     insn,
  output rv_core_pkg::word_t     mem_rdata
);
  import rv_core_pkg::*;

  word_t     mem [MEM_WORDS];
  mem_addr_t fetch_idx;
  mem_addr_t data_idx;

  assign fetch_idx = fetch_pc[MEM_ADDR_W+1:2];
  assign data_idx  = data_addr[MEM_ADDR_W+1:2];

  // Program load owns the array during reset
  always_ff @(posedge clk) begin
    if (rst) begin
      if (load_we) begin
        mem[load_addr] <= load_data;
      end
    end else begin
      for (int i = 0; i < $bits(byte_en_t); i++) begin
        if (store_en[i]) begin
          mem[data_idx][8*i +: 8] <= store_data[8*i +: 8];
        end
      end
    end
  end

  // Same-cycle reads see the contents before a store lands
  assign insn      = mem[fetch_idx];
  assign mem_rdata = mem[data_idx];

  a_fetch_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_pc[1:0] == 2'b00);
  a_data_aligned: assert property (@(posedge clk) disable iff (rst)
    data_addr[1:0] == 2'b00);

endmodule

//--- core/rv_core.sv
////////////////////////////////////////
// Single-cycle RV32I core with a retire
// trace of each committed instruction
////////////////////////////////////////
module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_core_pkg::word_t    insn,
  input  rv_core_pkg::word_t    load_data,
  output rv_core_pkg::word_t    fetch_pc,
  output rv_core_pkg::word_t    data_addr,
  output rv_core_pkg::byte_en_t store_en,
  output rv_core_pkg::word_t    store_data,
  output logic                  halt,
  output logic                  retire_valid,
  output rv_core_pkg::word_t    retire_pc,
  output logic                  retire_rd_we,
  output rv_core_pkg::reg_idx_t retire_rd,
  output rv_core_pkg::word_t    retire_rd_data,
  output rv_core_pkg::byte_en_t retire_store_en,
  output rv_core_pkg::word_t    retire_store_addr,
  output rv_core_pkg::word_t    retire_store_data
);
  import rv_core_pkg::*;

  opcode_t  opcode;
  funct3_t  funct3;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm;
  alu_op_t  alu_op;
  logic     alu_use_imm;
  logic     rd_we;
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  logic     is_load;
  logic     is_store;
  logic     is_ecall;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_b;
  word_t    alu_result;
  word_t    pc;
  word_t    link_pc;
  logic     running;
  byte_en_t lsu_store_en;
  word_t    load_result;
  word_t    wb_data;
  logic     rf_we;

  rv_decoder u_decoder (
    .insn        (insn),
    .opcode      (opcode),
    .funct3      (funct3),
    .rd          (rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .imm         (imm),
    .alu_op      (alu_op),
    .alu_use_imm (alu_use_imm),
    .rd_we       (rd_we),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_load     (is_load),
    .is_store    (is_store),
    .is_ecall    (is_ecall)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd       (rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_b = alu_use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .alu_op (alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .pc     (pc),
    .result (alu_result)
  );

  rv_next_pc u_next_pc (
    .clk             (clk),
    .rst             (rst),
    .insn_valid_halt (is_ecall),
    .is_branch       (is_branch),
    .is_jal          (is_jal),
    .is_jalr         (is_jalr),
    .funct3          (funct3),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .imm             (imm),
    .pc              (pc),
    .link_pc         (link_pc),
    .running         (running)
  );

  rv_lsu u_lsu (
    .is_load     (is_load),
    .is_store    (is_store),
    .funct3      (funct3),
    .base        (rs1_data),
    .imm         (imm),
    .rs2_data    (rs2_data),
    .mem_rdata   (load_data),
    .data_addr   (data_addr),
    .store_en    (lsu_store_en),
    .store_data  (store_data),
    .load_result (load_result)
  );

  always_comb begin
    case (opcode)
      OP_LOAD:         wb_data = load_result;
      OP_JAL, OP_JALR: wb_data = link_pc;
      default:         wb_data = alu_result;
    endcase
  end

  // Writes only commit while running
  assign rf_we    = rd_we && running;
  assign store_en = running ? lsu_store_en : '0;
  assign fetch_pc = pc;
  // Halted is the one state that is neither running nor in reset
  assign halt     = !(running || rst);

  assign retire_valid      = running;
  assign retire_pc         = pc;
  assign retire_rd_we      = rf_we;
  assign retire_rd         = rd;
  assign retire_rd_data    = wb_data;
  assign retire_store_en   = store_en;
  assign retire_store_addr = data_addr;
  assign retire_store_data = store_data;

endmodule

//--- core/rv_lsu.sv
////////////////////////////////////////
// Load/store lane handling: byte enables,
// store replication and load extension
////////////////////////////////////////
module rv_lsu (
  input  logic                  is_load,
  input  logic                  is_store,
  input  rv_core_pkg::funct3_t  funct3,
  input  rv_core_pkg::word_t    base,
  input  rv_core_pkg::word_t    imm,
  input  rv_core_pkg::word_t    rs2_data,
  input  rv_core_pkg::word_t    mem_rdata,
  output rv_core_pkg::word_t    data_addr,
  output rv_core_pkg::byte_en_t store_en,
  output rv_core_pkg::word_t    store_data,
  output rv_core_pkg::word_t    load_result
);
  import rv_core_pkg::*;

  word_t addr;
  word_t lane_data;
  logic  aligned;

  assign addr      = base + imm;
  assign data_addr = {addr[XLEN-1:2], 2'b00};

  // funct3[1:0] gives the access size
  always_comb begin
    case (funct3[1:0])
      2'b00:   aligned = 1'b1;
      2'b01:   aligned = !addr[0];
      default: aligned = (addr[1:0] == 2'b00);
    endcase
  end

  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        store_en   = 4'b0001 << addr[1:0];
        store_data = {4{rs2_data[7:0]}};
      end
      2'b01: begin
        store_en   = 4'b0011 << {addr[1], 1'b0};
        store_data = {2{rs2_data[15:0]}};
      end
      default: begin
        store_en   = 4'b1111;
        store_data = rs2_data;
      end
    endcase
    if (!(is_store && aligned)) begin
      store_en = '0;
    end
  end

  // Addressed byte or halfword moved down to lane 0
  assign lane_data = mem_rdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (funct3)
      3'b000:  load_result = {{24{lane_data[7]}}, lane_data[7:0]};
      3'b001:  load_result = {{16{lane_data[15]}}, lane_data[15:0]};
      3'b100:  load_result = {24'b0, lane_data[7:0]};
      3'b101:  load_result = {16'b0, lane_data[15:0]};
      default: load_result = mem_rdata;
    endcase
    if (!(is_load && aligned)) begin
      load_result = '0;
    end
  end

endmodule

//--- core/rv_next_pc.sv
////////////////////////////////////////
// Program counter, branch resolution and
// the run/halt state of the core
////////////////////////////////////////
module rv_next_pc (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 insn_valid_halt,
  input  logic                 is_branch,
  input  logic                 is_jal,
  input  logic                 is_jalr,
  input  rv_core_pkg::funct3_t funct3,
  input  rv_core_pkg::word_t   rs1_data,
  input  rv_core_pkg::word_t   rs2_data,
  input  rv_core_pkg::word_t   imm,
  output rv_core_pkg::word_t   pc,
  output rv_core_pkg::word_t   link_pc,
  output logic                 running
);
  import rv_core_pkg::*;

  core_state_t state;
  word_t       jalr_sum;
  word_t       pc_next;
  logic        taken;

  always_comb begin
    case (funct3)
      3'b000:  taken = (rs1_data == rs2_data);
      3'b001:  taken = (rs1_data != rs2_data);
      3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data < rs2_data;
      3'b111:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign link_pc  = pc + 32'd4;
  assign jalr_sum = rs1_data + imm;

  always_comb begin
    if ((is_branch && taken) || is_jal) begin
      pc_next = pc + imm;
    end else if (is_jalr) begin
      pc_next = {jalr_sum[XLEN-1:1], 1'b0};
    end else begin
      pc_next = link_pc;
    end
  end

  // The pc stays on the ecall once halted
  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= RESET_PC;
      state <= RUN;
    end else if (state == RUN) begin
      if (insn_valid_halt) begin
        state <= HALTED;
      end else begin
        pc <= pc_next;
      end
    end
  end

  // Nothing commits while memory is being loaded
  assign running = (state == RUN) && !rst;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    running |-> pc[1:0] == 2'b00);

endmodule

//--- core/rv_alu.sv
////////////////////////////////////////
// Integer ALU for the OP and OP-IMM groups,
// plus the lui and auipc results
////////////////////////////////////////
module rv_alu (
  input  rv_core_pkg::alu_op_t alu_op,
  input  rv_core_pkg::word_t   a,
  input  rv_core_pkg::word_t   b,
  input  rv_core_pkg::word_t   pc,
  output rv_core_pkg::word_t   result
);
  import rv_core_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = word_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      // lui
      ALU_PASS_B: result = b;
      // auipc
      ALU_PC_ADD: result = pc + b;
      default:    result = '0;
    endcase
  end

endmodule

//--- core/rv_regfile.sv
////////////////////////////////////////
// Integer register file, two async reads
// and one write per clock
////////////////////////////////////////
module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  rv_core_pkg::reg_idx_t rd,
  input  rv_core_pkg::word_t    rd_data,
  input  rv_core_pkg::reg_idx_t rs1,
  input  rv_core_pkg::reg_idx_t rs2,
  output rv_core_pkg::word_t    rs1_data,
  output rv_core_pkg::word_t    rs2_data
);
  import rv_core_pkg::*;

  word_t regs [32];

  // Entry 0 is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

//--- core/rv_decoder.sv
////////////////////////////////////////
// Instruction decode: fields, class flags,
// ALU operation and the format's immediate
////////////////////////////////////////
module rv_decoder (
  input  rv_core_pkg::word_t    insn,
  output rv_core_pkg::opcode_t  opcode,
  output rv_core_pkg::funct3_t  funct3,
  output rv_core_pkg::reg_idx_t rd,
  output rv_core_pkg::reg_idx_t rs1,
  output rv_core_pkg::reg_idx_t rs2,
  output rv_core_pkg::word_t    imm,
  output rv_core_pkg::alu_op_t  alu_op,
  output logic                  alu_use_imm,
  output logic                  rd_we,
  output logic                  is_branch,
  output logic                  is_jal,
  output logic                  is_jalr,
  output logic                  is_load,
  output logic                  is_store,
  output logic                  is_ecall
);
  import rv_core_pkg::*;

  logic [6:0] raw_funct7;
  funct3_t    raw_funct3;
  logic       alt;
  logic       legal;
  word_t      insn_q;

  function automatic alu_op_t op_from_funct3(funct3_t f3, logic alt_bit);
    case (f3)
      3'b000:  return alt_bit ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt_bit ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign raw_funct7 = insn[31:25];
  assign raw_funct3 = insn[14:12];
  assign alt        = (raw_funct7 == FUNCT7_ALT);

  always_comb begin
    legal       = 1'b0;
    alu_op      = ALU_ADD;
    alu_use_imm = 1'b0;
    rd_we       = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_ecall    = 1'b0;
    case (opcode_t'(insn[6:0]))
      OP_LUI, OP_AUIPC: begin
        legal       = 1'b1;
        rd_we       = 1'b1;
        alu_use_imm = 1'b1;
        alu_op      = (insn[6:0] == OP_LUI) ? ALU_PASS_B : ALU_PC_ADD;
      end
      OP_JAL: begin
        legal  = 1'b1;
        rd_we  = 1'b1;
        is_jal = 1'b1;
      end
      OP_JALR: begin
        legal   = (raw_funct3 == 3'b000);
        rd_we   = 1'b1;
        is_jalr = 1'b1;
      end
      OP_BRANCH: begin
        // funct3 010 and 011 are unassigned
        legal     = (raw_funct3[2:1] != 2'b01);
        is_branch = 1'b1;
      end
      OP_LOAD: begin
        legal   = raw_funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        rd_we   = 1'b1;
        is_load = 1'b1;
      end
      OP_STORE: begin
        legal    = raw_funct3 inside {3'b000, 3'b001, 3'b010};
        is_store = 1'b1;
      end
      OP_REG_IMM: begin
        // Only the shifts constrain funct7
        legal = (raw_funct3 == 3'b001) ? (raw_funct7 == '0) :
                (raw_funct3 == 3'b101) ? (raw_funct7 == '0 || alt) : 1'b1;
        rd_we       = 1'b1;
        alu_use_imm = 1'b1;
        alu_op      = op_from_funct3(raw_funct3, alt && raw_funct3 == 3'b101);
      end
      OP_REG_REG: begin
        legal  = (raw_funct7 == '0) || (alt && raw_funct3 inside {3'b000, 3'b101});
        rd_we  = 1'b1;
        alu_op = op_from_funct3(raw_funct3, alt);
      end
      OP_MISC_MEM: legal = (raw_funct3 == 3'b000);
      OP_ENVIRON: begin
        legal    = (insn[31:7] == '0);
        is_ecall = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      rd_we     = 1'b0;
      is_branch = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      is_load   = 1'b0;
      is_store  = 1'b0;
      is_ecall  = 1'b0;
    end
  end

  // Illegal encodings present the fields of a nop downstream
  assign insn_q = legal ? insn : NOP_INSN;

  assign opcode = opcode_t'(insn_q[6:0]);
  assign funct3 = insn_q[14:12];
  assign rd     = insn_q[11:7];
  assign rs1    = insn_q[19:15];
  assign rs2    = insn_q[24:20];

  always_comb begin
    case (opcode)
      OP_STORE:         imm = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
      OP_BRANCH:        imm = {{19{insn_q[31]}}, insn_q[31], insn_q[7], insn_q[30:25],
                               insn_q[11:8], 1'b0};
      OP_LUI, OP_AUIPC: imm = {insn_q[31:12], 12'b0};
      OP_JAL:           imm = {{11{insn_q[31]}}, insn_q[31], insn_q[19:12], insn_q[20],
                               insn_q[30:21], 1'b0};
      default:          imm = {{20{insn_q[31]}}, insn_q[31:20]};
    endcase
  end

endmodule

//--- common/rv_core_pkg.sv
////////////////////////////////////////
// Widths, opcodes and ALU encodings shared by
// the core and memory; imported by every RTL file
////////////////////////////////////////
package rv_core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      byte_en_t;
  typedef logic [2:0]      funct3_t;

  // Unified memory, word addressed
  localparam int MEM_WORDS  = 1024;
  localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b00_000_11,
    OP_STORE    = 7'b01_000_11,
    OP_BRANCH   = 7'b11_000_11,
    OP_JALR     = 7'b11_001_11,
    OP_MISC_MEM = 7'b00_011_11,
    OP_JAL      = 7'b11_011_11,
    OP_REG_IMM  = 7'b00_100_11,
    OP_REG_REG  = 7'b01_100_11,
    OP_ENVIRON  = 7'b11_100_11,
    OP_AUIPC    = 7'b00_101_11,
    OP_LUI      = 7'b01_101_11
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,
    ALU_PC_ADD
  } alu_op_t;

  typedef enum logic {
    RUN,
    HALTED
  } core_state_t;

  // funct7 for sub and sra/srai
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // addi x0, x0, 0
  localparam word_t NOP_INSN = 32'h0000_0013;

  localparam word_t RESET_PC = '0;

endpackage
